/* common/cdb_if.sv */
`timescale 1ns/1ps

// Result broadcast from the ROB to every station
interface cdb_if;

  logic                            valid;
  logic [rs_pkg::ROB_IDX_SIZE-1:0] tag;
  logic [rs_pkg::GPR_SIZE-1:0]     value;
  logic                            set_nzcv;
  rs_pkg::nzcv_t                   nzcv;

  modport source (
    output valid, tag, value, set_nzcv, nzcv
  );

  modport sink (
    input valid, tag, value, set_nzcv, nzcv
  );

endinterface

/* common/dispatch_if.sv */
`timescale 1ns/1ps

// One renamed instruction towards a single station
interface dispatch_if;

  logic                            strobe;
  rs_pkg::fu_op_t                  op;
  rs_pkg::cond_t                   cond;
  rs_pkg::operand_t                a;
  rs_pkg::operand_t                b;
  logic [rs_pkg::ROB_IDX_SIZE-1:0] dst_tag;
  logic                            set_nzcv;
  logic                            uses_nzcv;
  logic                            nzcv_valid;
  rs_pkg::nzcv_t                   nzcv;
  logic [rs_pkg::ROB_IDX_SIZE-1:0] nzcv_tag;
  logic                            full;

  modport router (
    output strobe, op, cond, a, b, dst_tag,
    output set_nzcv, uses_nzcv, nzcv_valid, nzcv, nzcv_tag,
    input  full
  );

  modport station (
    input  strobe, op, cond, a, b, dst_tag,
    input  set_nzcv, uses_nzcv, nzcv_valid, nzcv, nzcv_tag,
    output full
  );

endinterface

/* common/rs_pkg.sv */
package rs_pkg;

  localparam int GPR_SIZE     = 64;
  localparam int ROB_IDX_SIZE = 4;
  localparam int RS_SIZE      = 8;
  localparam int RS_IDX_SIZE  = 3;

  // Target functional unit of a dispatched instruction
  typedef enum logic {
    FU_ALU,
    FU_LS
  } fu_t;

  typedef enum logic [2:0] {
    FU_OP_ADD,
    FU_OP_SUB,
    FU_OP_AND,
    FU_OP_ORR,
    FU_OP_CMP,
    FU_OP_LDUR,
    FU_OP_STUR
  } fu_op_t;

  // ARM condition codes, only evaluated by the ALU
  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT,
    COND_GT, COND_LE, COND_AL, COND_NV
  } cond_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  // Source operand, either a value or the ROB tag that will produce it
  typedef struct packed {
    logic                    valid;
    logic [GPR_SIZE-1:0]     value;
    logic [ROB_IDX_SIZE-1:0] tag;
  } operand_t;

  typedef struct packed {
    logic                    valid;
    fu_op_t                  op;
    operand_t                a;
    operand_t                b;
    logic [ROB_IDX_SIZE-1:0] dst_tag;
    cond_t                   cond;
    logic                    set_nzcv;
    logic                    uses_nzcv;
    logic                    nzcv_valid;
    nzcv_t                   nzcv;
    logic [ROB_IDX_SIZE-1:0] nzcv_tag;
  } rs_entry_t;

endpackage

/* design/dispatch_router.sv */
`timescale 1ns/1ps

module dispatch_router (
  input  logic                            in_clk,
  input  logic                            in_rst_n,
  input  logic                            in_dispatch,
  input  rs_pkg::fu_t                     in_fu_id,
  input  rs_pkg::fu_op_t                  in_op,
  input  rs_pkg::cond_t                   in_cond,
  input  logic                            in_a_valid,
  input  logic [rs_pkg::GPR_SIZE-1:0]     in_a_value,
  input  logic [rs_pkg::ROB_IDX_SIZE-1:0] in_a_tag,
  input  logic                            in_b_valid,
  input  logic [rs_pkg::GPR_SIZE-1:0]     in_b_value,
  input  logic [rs_pkg::ROB_IDX_SIZE-1:0] in_b_tag,
  input  logic [rs_pkg::ROB_IDX_SIZE-1:0] in_dst_tag,
  input  logic                            in_set_nzcv,
  input  logic                            in_uses_nzcv,
  input  logic                            in_nzcv_valid,
  input  rs_pkg::nzcv_t                   in_nzcv,
  input  logic [rs_pkg::ROB_IDX_SIZE-1:0] in_nzcv_tag,
  input  logic                            in_stur_done,
  input  logic                            in_mispredict,
  dispatch_if.router                      alu_port,
  dispatch_if.router                      ls_port,
  output logic                            stores_pending
);

  import rs_pkg::*;

  operand_t                op_a;
  operand_t                op_b;
  logic [ROB_IDX_SIZE:0]   store_count;
  logic                    store_in;
  logic                    store_out;

  assign op_a = '{valid: in_a_valid, value: in_a_value, tag: in_a_tag};
  assign op_b = '{valid: in_b_valid, value: in_b_value, tag: in_b_tag};

  // Only the addressed station sees the strobe
  assign alu_port.strobe = in_dispatch && (in_fu_id == FU_ALU);
  assign ls_port.strobe  = in_dispatch && (in_fu_id == FU_LS);

  assign alu_port.op         = in_op;
  assign alu_port.cond       = in_cond;
  assign alu_port.a          = op_a;
  assign alu_port.b          = op_b;
  assign alu_port.dst_tag    = in_dst_tag;
  assign alu_port.set_nzcv   = in_set_nzcv;
  assign alu_port.uses_nzcv  = in_uses_nzcv;
  assign alu_port.nzcv_valid = in_nzcv_valid;
  assign alu_port.nzcv       = in_nzcv;
  assign alu_port.nzcv_tag   = in_nzcv_tag;

  assign ls_port.op         = in_op;
  assign ls_port.cond       = in_cond;
  assign ls_port.a          = op_a;
  assign ls_port.b          = op_b;
  assign ls_port.dst_tag    = in_dst_tag;
  assign ls_port.set_nzcv   = in_set_nzcv;
  assign ls_port.uses_nzcv  = in_uses_nzcv;
  assign ls_port.nzcv_valid = in_nzcv_valid;
  assign ls_port.nzcv       = in_nzcv;
  assign ls_port.nzcv_tag   = in_nzcv_tag;

  // A store counts once the LS station actually accepts it
  assign store_in  = ls_port.strobe && !ls_port.full && (in_op == FU_OP_STUR);
  assign store_out = in_stur_done && (store_count != '0);

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      store_count <= '0;
    end else if (in_mispredict) begin
      store_count <= '0;
    end else if (store_in && !store_out) begin
      store_count <= store_count + 1'b1;
    end else if (store_out && !store_in) begin
      store_count <= store_count - 1'b1;
    end
  end

  assign stores_pending = (store_count != '0);

endmodule

/* design/reservation_stations.sv */
`timescale 1ns/1ps

module reservation_stations (
  input  logic                            in_clk,
  input  logic                            in_rst_n,
  // Renamed instruction from the ROB
  input  logic                            in_dispatch,
  input  rs_pkg::fu_t                     in_fu_id,
  input  rs_pkg::fu_op_t                  in_op,
  input  rs_pkg::cond_t                   in_cond,
  input  logic                            in_a_valid,
  input  logic [rs_pkg::GPR_SIZE-1:0]     in_a_value,
  input  logic [rs_pkg::ROB_IDX_SIZE-1:0] in_a_tag,
  input  logic                            in_b_valid,
  input  logic [rs_pkg::GPR_SIZE-1:0]     in_b_value,
  input  logic [rs_pkg::ROB_IDX_SIZE-1:0] in_b_tag,
  input  logic [rs_pkg::ROB_IDX_SIZE-1:0] in_dst_tag,
  input  logic                            in_set_nzcv,
  input  logic                            in_uses_nzcv,
  input  logic                            in_nzcv_valid,
  input  rs_pkg::nzcv_t                   in_nzcv,
  input  logic [rs_pkg::ROB_IDX_SIZE-1:0] in_nzcv_tag,
  // Result broadcast
  input  logic                            in_cdb_valid,
  input  logic [rs_pkg::ROB_IDX_SIZE-1:0] in_cdb_tag,
  input  logic [rs_pkg::GPR_SIZE-1:0]     in_cdb_value,
  input  logic                            in_cdb_set_nzcv,
  input  rs_pkg::nzcv_t                   in_cdb_nzcv,
  input  logic                            in_stur_done,
  input  logic                            in_mispredict,
  input  logic                            in_alu_ready,
  input  logic                            in_ls_ready,
  output logic                            alu_full,
  output logic                            ls_full,
  // ALU issue
  output logic                            alu_start,
  output rs_pkg::fu_op_t                  alu_op,
  output logic [rs_pkg::GPR_SIZE-1:0]     alu_a,
  output logic [rs_pkg::GPR_SIZE-1:0]     alu_b,
  output logic [rs_pkg::ROB_IDX_SIZE-1:0] alu_dst_tag,
  output rs_pkg::cond_t                   alu_cond,
  output logic                            alu_set_nzcv,
  output rs_pkg::nzcv_t                   alu_nzcv,
  // LS issue
  output logic                            ls_start,
  output rs_pkg::fu_op_t                  ls_op,
  output logic [rs_pkg::GPR_SIZE-1:0]     ls_a,
  output logic [rs_pkg::GPR_SIZE-1:0]     ls_b,
  output logic [rs_pkg::ROB_IDX_SIZE-1:0] ls_dst_tag
);

  import rs_pkg::*;

  logic alu_ready_q;
  logic ls_ready_q;
  logic stores_pending;

  cdb_if      cdb ();
  dispatch_if alu_disp ();
  dispatch_if ls_disp ();

  // Unit ready levels take one cycle to reach the stations
  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      alu_ready_q <= 1'b0;
      ls_ready_q  <= 1'b0;
    end else begin
      alu_ready_q <= in_alu_ready;
      ls_ready_q  <= in_ls_ready;
    end
  end

  assign cdb.valid    = in_cdb_valid;
  assign cdb.tag      = in_cdb_tag;
  assign cdb.value    = in_cdb_value;
  assign cdb.set_nzcv = in_cdb_set_nzcv;
  assign cdb.nzcv     = in_cdb_nzcv;

  dispatch_router router_inst (
    .alu_port       (alu_disp),
    .ls_port        (ls_disp),
    .stores_pending (stores_pending),
    .*
  );

  reservation_station alu_rs (
    .in_clk        (in_clk),
    .in_rst_n      (in_rst_n),
    .in_flush      (in_mispredict),
    .in_fu_ready   (alu_ready_q),
    .in_hold_loads (1'b0),
    .disp          (alu_disp),
    .cdb           (cdb),
    .out_start     (alu_start),
    .out_op        (alu_op),
    .out_a         (alu_a),
    .out_b         (alu_b),
    .out_dst_tag   (alu_dst_tag),
    .out_cond      (alu_cond),
    .out_set_nzcv  (alu_set_nzcv),
    .out_nzcv      (alu_nzcv)
  );

  // Loads wait here for older stores, so only this station gets the hold
  reservation_station ls_rs (
    .in_clk        (in_clk),
    .in_rst_n      (in_rst_n),
    .in_flush      (in_mispredict),
    .in_fu_ready   (ls_ready_q),
    .in_hold_loads (stores_pending),
    .disp          (ls_disp),
    .cdb           (cdb),
    .out_start     (ls_start),
    .out_op        (ls_op),
    .out_a         (ls_a),
    .out_b         (ls_b),
    .out_dst_tag   (ls_dst_tag),
    .out_cond      (),
    .out_set_nzcv  (),
    .out_nzcv      ()
  );

  assign alu_full = alu_disp.full;
  assign ls_full  = ls_disp.full;

endmodule

/* reservation_station/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station (
  input  logic                            in_clk,
  input  logic                            in_rst_n,
  input  logic                            in_flush,
  input  logic                            in_fu_ready,
  input  logic                            in_hold_loads,
  dispatch_if.station                     disp,
  cdb_if.sink                             cdb,
  output logic                            out_start,
  output rs_pkg::fu_op_t                  out_op,
  output logic [rs_pkg::GPR_SIZE-1:0]     out_a,
  output logic [rs_pkg::GPR_SIZE-1:0]     out_b,
  output logic [rs_pkg::ROB_IDX_SIZE-1:0] out_dst_tag,
  output rs_pkg::cond_t                   out_cond,
  output logic                            out_set_nzcv,
  output rs_pkg::nzcv_t                   out_nzcv
);

  import rs_pkg::*;

  rs_entry_t [RS_SIZE-1:0] entries;
  rs_entry_t [RS_SIZE-1:0] woken;
  rs_entry_t               incoming;

  logic [RS_SIZE-1:0]     valid_bits;
  logic [RS_SIZE-1:0]     ready_bits;
  logic [RS_IDX_SIZE-1:0] free_idx;
  logic [RS_IDX_SIZE-1:0] ready_idx;
  logic                   ready_found;
  logic                   insert;
  logic                   issue;

  // Capture a matching broadcast; memory ops add the base to the offset held in a
  function automatic operand_t wake_operand(operand_t opnd, logic accumulate, logic allow);
    operand_t res;
    res = opnd;
    if (allow && cdb.valid && !opnd.valid && (cdb.tag == opnd.tag)) begin
      res.valid = 1'b1;
      res.value = accumulate ? (opnd.value + cdb.value) : cdb.value;
    end
    return res;
  endfunction

  function automatic rs_entry_t wake_entry(rs_entry_t e);
    rs_entry_t res;
    logic      allow;
    logic      mem_op;
    res    = e;
    // Loads stay asleep behind older stores
    allow  = !(in_hold_loads && (e.op == FU_OP_LDUR));
    mem_op = (e.op == FU_OP_LDUR) || (e.op == FU_OP_STUR);
    res.a  = wake_operand(e.a, mem_op, allow);
    res.b  = wake_operand(e.b, 1'b0, allow);
    if (cdb.valid && cdb.set_nzcv && e.uses_nzcv && !e.nzcv_valid &&
        (cdb.tag == e.nzcv_tag)) begin
      res.nzcv_valid = 1'b1;
      res.nzcv       = cdb.nzcv;
    end
    return res;
  endfunction

  // New entry, with the same-cycle broadcast already applied
  always_comb begin
    incoming.valid      = 1'b1;
    incoming.op         = disp.op;
    incoming.a          = disp.a;
    incoming.b          = disp.b;
    incoming.dst_tag    = disp.dst_tag;
    incoming.cond       = disp.cond;
    incoming.set_nzcv   = disp.set_nzcv;
    incoming.uses_nzcv  = disp.uses_nzcv;
    incoming.nzcv_valid = disp.nzcv_valid;
    incoming.nzcv       = disp.nzcv;
    incoming.nzcv_tag   = disp.nzcv_tag;
    incoming            = wake_entry(incoming);
  end

  always_comb begin
    for (int i = 0; i < RS_SIZE; i++) begin
      woken[i]      = wake_entry(entries[i]);
      valid_bits[i] = entries[i].valid;
      ready_bits[i] = entries[i].valid && entries[i].a.valid && entries[i].b.valid &&
                      (entries[i].nzcv_valid || !entries[i].uses_nzcv);
    end
  end

  // Lowest index wins for both the free slot and the issue slot
  always_comb begin
    free_idx    = '0;
    ready_idx   = '0;
    ready_found = 1'b0;
    for (int i = RS_SIZE - 1; i >= 0; i--) begin
      if (!valid_bits[i]) begin
        free_idx = RS_IDX_SIZE'(i);
      end
      if (ready_bits[i]) begin
        ready_idx   = RS_IDX_SIZE'(i);
        ready_found = 1'b1;
      end
    end
  end

  assign disp.full = &valid_bits;
  assign insert    = disp.strobe && !disp.full;
  assign issue     = in_fu_ready && ready_found;

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      entries <= '0;
    end else if (in_flush) begin
      for (int i = 0; i < RS_SIZE; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < RS_SIZE; i++) begin
        entries[i] <= woken[i];
        if (issue && (ready_idx == RS_IDX_SIZE'(i))) begin
          entries[i].valid <= 1'b0;
        end
        if (insert && (free_idx == RS_IDX_SIZE'(i))) begin
          entries[i] <= incoming;
        end
      end
    end
  end

  // Issue payload straight from the selected entry
  assign out_start    = issue;
  assign out_op       = entries[ready_idx].op;
  assign out_a        = entries[ready_idx].a.value;
  assign out_b        = entries[ready_idx].b.value;
  assign out_dst_tag  = entries[ready_idx].dst_tag;
  assign out_cond     = entries[ready_idx].cond;
  assign out_set_nzcv = entries[ready_idx].set_nzcv;
  assign out_nzcv     = entries[ready_idx].nzcv;

endmodule

/* sim/rs_checker.sv */
`timescale 1ns/1ps

module rs_checker (
  input logic in_clk,
  input logic in_rst_n,
  input logic in_mispredict,
  input logic alu_start,
  input logic ls_start,
  input logic alu_ready_q,
  input logic ls_ready_q,
  input logic alu_full,
  input logic ls_full
);

  int reset_fails = 0;
  int ready_fails = 0;
  int flush_fails = 0;
  int fail_count;

  assign fail_count = reset_fails + ready_fails + flush_fails;

  // No issue while the core is held in reset
  start_in_reset : assert property (@(posedge in_clk) !in_rst_n |-> (!alu_start && !ls_start))
    else begin
      $error("start raised while reset is active");
      reset_fails++;
    end

  // A unit only receives work after its registered ready level
  start_needs_ready : assert property (@(posedge in_clk) disable iff (!in_rst_n)
    (!alu_start || alu_ready_q) && (!ls_start || ls_ready_q))
    else begin
      $error("start raised without the registered ready level");
      ready_fails++;
    end

  flush_empties : assert property (@(posedge in_clk) disable iff (!in_rst_n)
    in_mispredict |=> (!alu_full && !ls_full))
    else begin
      $error("station still full the cycle after a mispredict");
      flush_fails++;
    end

endmodule

/* sim/tb_reservation_stations.sv */
`timescale 1ns/1ps

module tb_reservation_stations;

  import rs_pkg::*;

  // Expected issue payload, in issue order
  typedef struct packed {
    fu_op_t                  op;
    logic [GPR_SIZE-1:0]     a;
    logic [GPR_SIZE-1:0]     b;
    logic [ROB_IDX_SIZE-1:0] dst;
    cond_t                   cond;
    logic                    set_nzcv;
    nzcv_t                   nzcv;
  } issue_t;

  logic                    in_clk, in_rst_n;
  logic                    in_dispatch;
  fu_t                     in_fu_id;
  fu_op_t                  in_op;
  cond_t                   in_cond;
  logic                    in_a_valid, in_b_valid;
  logic [GPR_SIZE-1:0]     in_a_value, in_b_value, in_cdb_value;
  logic [ROB_IDX_SIZE-1:0] in_a_tag, in_b_tag, in_dst_tag, in_nzcv_tag, in_cdb_tag;
  logic                    in_set_nzcv, in_uses_nzcv, in_nzcv_valid;
  nzcv_t                   in_nzcv, in_cdb_nzcv;
  logic                    in_cdb_valid, in_cdb_set_nzcv;
  logic                    in_stur_done, in_mispredict, in_alu_ready, in_ls_ready;
  logic                    alu_full, ls_full, alu_start, ls_start, alu_set_nzcv;
  fu_op_t                  alu_op, ls_op;
  logic [GPR_SIZE-1:0]     alu_a, alu_b, ls_a, ls_b;
  logic [ROB_IDX_SIZE-1:0] alu_dst_tag, ls_dst_tag;
  cond_t                   alu_cond;
  nzcv_t                   alu_nzcv;

  issue_t alu_exp_q[$];
  issue_t ls_exp_q[$];
  string  test_name;
  int     check_errors = 0;
  int     timeouts = 0;
  int     seed = 32'h8cd2_0bc0;

  reservation_stations reservation_stations_inst (.*);

  bind reservation_stations rs_checker rs_checker_inst (
    .in_clk        (in_clk),
    .in_rst_n      (in_rst_n),
    .in_mispredict (in_mispredict),
    .alu_start     (alu_start),
    .ls_start      (ls_start),
    .alu_ready_q   (alu_ready_q),
    .ls_ready_q    (ls_ready_q),
    .alu_full      (alu_full),
    .ls_full       (ls_full)
  );

  always #10 in_clk = ~in_clk;

  function automatic operand_t ready_opnd(input logic [GPR_SIZE-1:0] value);
    return '{valid: 1'b1, value: value, tag: '0};
  endfunction

  // Waiting operand; the value field carries the address offset for memory ops
  function automatic operand_t wait_opnd(input logic [ROB_IDX_SIZE-1:0] tag,
                                         input logic [GPR_SIZE-1:0] offset);
    return '{valid: 1'b0, value: offset, tag: tag};
  endfunction

  function automatic logic [GPR_SIZE-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic dispatch(input fu_t fu, input fu_op_t op, input cond_t cond,
                          input operand_t a, input operand_t b,
                          input logic [ROB_IDX_SIZE-1:0] dst, input logic uses_flags,
                          input logic [ROB_IDX_SIZE-1:0] flag_tag);
    @(posedge in_clk);
    in_dispatch   <= 1'b1;
    in_fu_id      <= fu;
    in_op         <= op;
    in_cond       <= cond;
    in_a_valid    <= a.valid;
    in_a_value    <= a.value;
    in_a_tag      <= a.tag;
    in_b_valid    <= b.valid;
    in_b_value    <= b.value;
    in_b_tag      <= b.tag;
    in_dst_tag    <= dst;
    in_set_nzcv   <= (op == FU_OP_CMP);
    in_uses_nzcv  <= uses_flags;
    in_nzcv_valid <= !uses_flags;
    in_nzcv_tag   <= flag_tag;
    @(posedge in_clk);
    in_dispatch <= 1'b0;
  endtask

  task automatic broadcast(input logic [ROB_IDX_SIZE-1:0] tag, input logic [GPR_SIZE-1:0] value,
                           input logic set_flags, input nzcv_t flags);
    @(posedge in_clk);
    in_cdb_valid    <= 1'b1;
    in_cdb_tag      <= tag;
    in_cdb_value    <= value;
    in_cdb_set_nzcv <= set_flags;
    in_cdb_nzcv     <= flags;
    @(posedge in_clk);
    in_cdb_valid    <= 1'b0;
    in_cdb_set_nzcv <= 1'b0;
  endtask

  task automatic pulse_store_done();
    @(posedge in_clk);
    in_stur_done <= 1'b1;
    @(posedge in_clk);
    in_stur_done <= 1'b0;
  endtask

  task automatic pulse_mispredict();
    @(posedge in_clk);
    in_mispredict <= 1'b1;
    @(posedge in_clk);
    in_mispredict <= 1'b0;
  endtask

  task automatic set_ready(input logic alu, input logic ls);
    @(posedge in_clk);
    in_alu_ready <= alu;
    in_ls_ready  <= ls;
  endtask

  task automatic expect_alu(input fu_op_t op, input logic [GPR_SIZE-1:0] a,
                            input logic [GPR_SIZE-1:0] b, input logic [ROB_IDX_SIZE-1:0] dst,
                            input cond_t cond, input nzcv_t flags);
    alu_exp_q.push_back('{op: op, a: a, b: b, dst: dst, cond: cond,
                          set_nzcv: (op == FU_OP_CMP), nzcv: flags});
  endtask

  task automatic expect_ls(input fu_op_t op, input logic [GPR_SIZE-1:0] a,
                           input logic [GPR_SIZE-1:0] b, input logic [ROB_IDX_SIZE-1:0] dst);
    ls_exp_q.push_back('{op: op, a: a, b: b, dst: dst, cond: COND_AL,
                         set_nzcv: 1'b0, nzcv: '0});
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((alu_exp_q.size() != 0 || ls_exp_q.size() != 0) && cycles < 40) begin
      @(negedge in_clk);
      cycles++;
    end
    if (alu_exp_q.size() != 0 || ls_exp_q.size() != 0) begin
      $display("Timeout in %s: an expected instruction never issued", test_name);
      timeouts++;
      alu_exp_q.delete();
      ls_exp_q.delete();
    end
  endtask

  task automatic check_value(input string field, input logic [GPR_SIZE-1:0] expected,
                             input logic [GPR_SIZE-1:0] actual);
    assert (expected === actual) else begin
      $display("FAIL %s %s expected %h actual %h", test_name, field, expected, actual);
      check_errors++;
    end
  endtask

  always @(negedge in_clk) begin : issue_monitor
    issue_t expected_issue;
    if (in_rst_n && alu_start) begin
      assert (alu_exp_q.size() != 0) else begin
        $display("Error in %s: ALU issued an instruction that was not expected", test_name);
        check_errors++;
      end
      if (alu_exp_q.size() != 0) begin
        expected_issue = alu_exp_q.pop_front();
        check_value("alu_op", expected_issue.op, alu_op);
        check_value("alu_a", expected_issue.a, alu_a);
        check_value("alu_b", expected_issue.b, alu_b);
        check_value("alu_dst_tag", expected_issue.dst, alu_dst_tag);
        check_value("alu_cond", expected_issue.cond, alu_cond);
        check_value("alu_set_nzcv", expected_issue.set_nzcv, alu_set_nzcv);
        check_value("alu_nzcv", expected_issue.nzcv, alu_nzcv);
      end
    end
    if (in_rst_n && ls_start) begin
      assert (ls_exp_q.size() != 0) else begin
        $display("Error in %s: LS issued an instruction that was not expected", test_name);
        check_errors++;
      end
      if (ls_exp_q.size() != 0) begin
        expected_issue = ls_exp_q.pop_front();
        check_value("ls_op", expected_issue.op, ls_op);
        check_value("ls_a", expected_issue.a, ls_a);
        check_value("ls_b", expected_issue.b, ls_b);
        check_value("ls_dst_tag", expected_issue.dst, ls_dst_tag);
      end
    end
  end

  initial begin
    logic [GPR_SIZE-1:0] a_val, b_val, base, data;
    int                  checker_fails;
    in_clk          = 1'b0;
    in_rst_n        = 1'b0;
    in_dispatch     = 1'b0;
    in_fu_id        = FU_ALU;
    in_op           = FU_OP_ADD;
    in_cond         = COND_AL;
    in_a_valid      = 1'b0;
    in_a_value      = '0;
    in_a_tag        = '0;
    in_b_valid      = 1'b0;
    in_b_value      = '0;
    in_b_tag        = '0;
    in_dst_tag      = '0;
    in_set_nzcv     = 1'b0;
    in_uses_nzcv    = 1'b0;
    in_nzcv_valid   = 1'b0;
    in_nzcv         = '0;
    in_nzcv_tag     = '0;
    in_cdb_valid    = 1'b0;
    in_cdb_tag      = '0;
    in_cdb_value    = '0;
    in_cdb_set_nzcv = 1'b0;
    in_cdb_nzcv     = '0;
    in_stur_done    = 1'b0;
    in_mispredict   = 1'b0;
    in_alu_ready    = 1'b0;
    in_ls_ready     = 1'b0;
    test_name       = "reset";
    repeat (8) @(posedge in_clk);
    in_rst_n <= 1'b1;

    // Ready operands wait for the unit, then issue unchanged
    test_name = "ready_operands";
    a_val = rand64();
    b_val = rand64();
    dispatch(FU_ALU, FU_OP_CMP, COND_GT, ready_opnd(a_val), ready_opnd(b_val), 4'd1, 1'b0, '0);
    repeat (6) @(posedge in_clk);
    expect_alu(FU_OP_CMP, a_val, b_val, 4'd1, COND_GT, '0);
    set_ready(1'b1, 1'b1);
    wait_drain();

    test_name = "tag_wakeup";
    a_val = rand64();
    b_val = rand64();
    base  = rand64();
    data  = rand64();
    // Stale values in ALU operands get replaced, not summed
    dispatch(FU_ALU, FU_OP_SUB, COND_AL, wait_opnd(4'd3, 64'h5a5a), wait_opnd(4'd4, 64'ha5a5),
             4'd2, 1'b0, '0);
    dispatch(FU_LS, FU_OP_STUR, COND_AL, wait_opnd(4'd5, 64'h10), ready_opnd(data), 4'd8, 1'b0, '0);
    broadcast(4'd3, a_val, 1'b0, '0);
    repeat (4) @(posedge in_clk);
    expect_alu(FU_OP_SUB, a_val, b_val, 4'd2, COND_AL, '0);
    broadcast(4'd4, b_val, 1'b0, '0);
    expect_ls(FU_OP_STUR, 64'h10 + base, data, 4'd8);
    broadcast(4'd5, base, 1'b0, '0);
    wait_drain();
    pulse_store_done();

    test_name = "flag_wakeup";
    dispatch(FU_ALU, FU_OP_ADD, COND_EQ, ready_opnd(a_val), ready_opnd(b_val), 4'd9, 1'b1, 4'd6);
    // Neither a flagless result on the tag nor flags from another tag may wake it
    broadcast(4'd6, rand64(), 1'b0, 4'b1000);
    broadcast(4'd5, rand64(), 1'b1, 4'b0010);
    repeat (4) @(posedge in_clk);
    expect_alu(FU_OP_ADD, a_val, b_val, 4'd9, COND_EQ, 4'b0100);
    broadcast(4'd6, rand64(), 1'b1, 4'b0100);
    wait_drain();

    // Load stays asleep until the older store completes
    test_name = "load_hold";
    data = rand64();
    base = rand64();
    expect_ls(FU_OP_STUR, 64'h20, data, 4'd10);
    dispatch(FU_LS, FU_OP_STUR, COND_AL, ready_opnd(64'h20), ready_opnd(data), 4'd10, 1'b0, '0);
    wait_drain();
    dispatch(FU_LS, FU_OP_LDUR, COND_AL, wait_opnd(4'd7, 64'h40), ready_opnd('0), 4'd11, 1'b0, '0);
    broadcast(4'd7, base, 1'b0, '0);
    repeat (4) @(posedge in_clk);
    pulse_store_done();
    expect_ls(FU_OP_LDUR, 64'h40 + base, '0, 4'd11);
    broadcast(4'd7, base, 1'b0, '0);
    wait_drain();

    test_name = "full_flush";
    for (int i = 0; i < RS_SIZE; i++) begin
      dispatch(FU_ALU, FU_OP_ORR, COND_AL, wait_opnd(4'd12, '0), ready_opnd(rand64()),
               ROB_IDX_SIZE'(i), 1'b0, '0);
    end
    @(negedge in_clk);
    check_value("alu_full", 1'b1, alu_full);
    check_value("ls_full", 1'b0, ls_full);
    pulse_mispredict();
    broadcast(4'd12, rand64(), 1'b0, '0);
    repeat (6) @(posedge in_clk);

    // Entries collect behind a stalled unit, then drain lowest index first
    test_name = "issue_order";
    set_ready(1'b0, 1'b1);
    for (int i = 0; i < 4; i++) begin
      a_val = rand64();
      b_val = rand64();
      expect_alu(FU_OP_AND, a_val, b_val, ROB_IDX_SIZE'(i + 1), COND_AL, '0);
      dispatch(FU_ALU, FU_OP_AND, COND_AL, ready_opnd(a_val), ready_opnd(b_val),
               ROB_IDX_SIZE'(i + 1), 1'b0, '0);
    end
    set_ready(1'b1, 1'b1);
    wait_drain();

    repeat (2) @(posedge in_clk);
    checker_fails = reservation_stations_inst.rs_checker_inst.fail_count;
    $display("Error counts: %0d check, %0d timeout, %0d assertion",
             check_errors, timeouts, checker_fails);
    if (check_errors == 0 && timeouts == 0 && checker_fails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* src.f */
common/rs_pkg.sv
common/cdb_if.sv
common/dispatch_if.sv
reservation_station/reservation_station.sv
design/dispatch_router.sv
design/reservation_stations.sv
sim/rs_checker.sv
sim/tb_reservation_stations.sv
